// ==== mem1rw.f ====
mem1rw_pkg.sv
mem_req_if.sv
addr_split.sv
err_tracker.sv
mem_core.sv
mem_arbiter.sv
row_scrubber.sv
mem1rw_top.sv
tb_clk_gen.sv
mem1rw_props.sv
mem1rw_tb.sv

// ==== mem1rw_tb.sv ====
`timescale 1ns/1ns

module mem1rw_tb;
  import mem1rw_pkg::*;

  localparam int width = def_width;
  localparam int nb = def_numvbnk;
  localparam int nr = def_numvrow;
  localparam int nw = def_numwrds;
  localparam int mem_delay = def_mem_delay;
  localparam int scrub_gap = 4;
  localparam int numaddr = nb * nr;
  localparam int bitaddr = $clog2(numaddr);
  localparam int bitibnk = $clog2(nb + 1);
  localparam int bitvrow = $clog2(nr);
  localparam int bitwrds = $clog2(nw);
  localparam int bitsrow = $clog2((nr + nw - 1) / nw);
  localparam int bitpadr = $clog2(nb) + bitwrds + bitsrow;
  localparam int op_cycles = mem_delay + scrub_gap + 4;
  // the scrub test idles two sweeps, counted as one op per address and sweep
  localparam int total_ops = 2 * numaddr + 4 + 5 + 4 + (4 + 3 * numaddr + 2) + (4 + 200);
  localparam int limit_ns = total_ops * op_cycles * 4 + 2000;

  typedef struct packed {
    logic [width-1:0]   data;
    logic               serr;
    logic               derr;
    logic [bitpadr-1:0] padr;
    logic               chk_sts;
  } exp_t;

  logic               clk;
  logic               rst;
  logic               read;
  logic               write;
  logic [bitaddr-1:0] addr;
  logic [width-1:0]   din;
  logic               inj;
  logic [bitibnk-1:0] inj_bank;
  logic [bitvrow-1:0] inj_row;
  logic               scrub_en;
  logic               read_vld;
  logic [width-1:0]   dout;
  logic               read_serr;
  logic               read_derr;
  logic [bitpadr-1:0] read_padr;

  // shadow state of the memory
  logic [width-1:0] mem_sh [numaddr];
  logic [nb:0]      flt_sh [nr];
  exp_t             exp_q [$];
  integer           seed;
  string            test_name;
  int               errors;
  int               checks;
  int               n_tests;
  int               err0;
  int               chk0;
  int               row_a;
  int               bank_a;
  int               row_b;
  int               bank_b;

  tb_clk_gen #(.period(4)) i_tb_clk_gen (.clk(clk));

  mem1rw_top #(
    .width     (width),
    .numvbnk   (nb),
    .numvrow   (nr),
    .numwrds   (nw),
    .mem_delay (mem_delay),
    .scrub_gap (scrub_gap)
  ) i_mem1rw_top (
    .clk       (clk),
    .rst       (rst),
    .read      (read),
    .write     (write),
    .addr      (addr),
    .din       (din),
    .inj       (inj),
    .inj_bank  (inj_bank),
    .inj_row   (inj_row),
    .scrub_en  (scrub_en),
    .read_vld  (read_vld),
    .dout      (dout),
    .read_serr (read_serr),
    .read_derr (read_derr),
    .read_padr (read_padr)
  );

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // status from the fault count on the row, padr names the first faulty bank
  function automatic exp_t expect_read(int a, bit chk);
    exp_t e;
    int   bank;
    int   row;
    int   cnt;
    int   low;
    bank = a % nb;
    row = a / nb;
    cnt = 0;
    low = bank;
    for (int b = 0; b <= nb; b++) begin
      if (flt_sh[row][b]) begin
        if (cnt == 0) begin
          low = b;
        end
        cnt++;
      end
    end
    e.data = mem_sh[a];
    e.serr = (cnt > 0);
    e.derr = (cnt > 1);
    e.padr = bitpadr'((low << (bitwrds + bitsrow)) | ((row % nw) << bitsrow) | (row / nw));
    e.chk_sts = chk;
    return e;
  endfunction

  function automatic int total_errors();
    return errors + i_mem1rw_top.i_props.fail_cnt;
  endfunction

  task automatic go_idle(int n);
    repeat (n) begin
      @(posedge clk);
      read <= 1'b0;
      write <= 1'b0;
      inj <= 1'b0;
    end
  endtask

  task automatic host_write(int a, logic [width-1:0] d);
    @(posedge clk);
    read <= 1'b0;
    write <= 1'b1;
    inj <= 1'b0;
    addr <= bitaddr'(a);
    din <= d;
    mem_sh[a] = d;
    flt_sh[a / nb][a % nb] = 1'b0;
    flt_sh[a / nb][nb] = 1'b0;
  endtask

  task automatic host_read(int a, bit chk);
    @(posedge clk);
    read <= 1'b1;
    write <= 1'b0;
    inj <= 1'b0;
    addr <= bitaddr'(a);
    exp_q.push_back(expect_read(a, chk));
  endtask

  task automatic inject_fault(int b, int r);
    @(posedge clk);
    read <= 1'b0;
    write <= 1'b0;
    inj <= 1'b1;
    inj_bank <= bitibnk'(b);
    inj_row <= bitvrow'(r);
    flt_sh[r][b] = 1'b1;
  endtask

  task automatic read_row(int r, bit chk);
    for (int k = 0; k < nb; k++) begin
      host_read(r * nb + k, chk);
    end
  endtask

  task automatic wait_results();
    int n;
    go_idle(1);
    n = 0;
    while (exp_q.size() > 0 && n < mem_delay + 8) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("%s: %0d read results never arrived", test_name, exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    err0 = total_errors();
    chk0 = checks;
  endtask

  task automatic finish_test();
    n_tests++;
    $display("test %s: %0d checks, %0d errors", test_name, checks - chk0,
             total_errors() - err0);
  endtask

  task automatic write_read_test();
    start_test("write_read");
    for (int a = 0; a < numaddr; a++) begin
      host_write(a, width'($random(seed)));
    end
    for (int a = 0; a < numaddr; a++) begin
      host_read(a, 1'b1);
    end
    wait_results();
    finish_test();
  endtask

  task automatic single_fault_test();
    start_test("single_fault");
    row_a = rand_below(nr);
    bank_a = rand_below(nb);
    inject_fault(bank_a, row_a);
    read_row(row_a, 1'b1);
    wait_results();
    finish_test();
  endtask

  task automatic double_fault_test();
    start_test("double_fault");
    row_b = (row_a + 1 + rand_below(nr - 1)) % nr;
    bank_b = rand_below(nb);
    inject_fault(bank_b, row_b);
    inject_fault(nb, row_b);
    read_row(row_b, 1'b1);
    wait_results();
    finish_test();
  endtask

  task automatic write_clear_test();
    start_test("write_clear");
    host_write(row_b * nb + bank_b, width'($random(seed)));
    read_row(row_b, 1'b1);
    wait_results();
    finish_test();
  endtask

  task automatic scrub_sweep_test();
    start_test("scrub_sweep");
    // row_a turns double, three other rows get one fault each
    inject_fault(nb, row_a);
    for (int k = 1; k <= 3; k++) begin
      inject_fault(rand_below(nb + 1), (row_a + 5 * k) % nr);
    end
    go_idle(1);
    scrub_en <= 1'b1;
    go_idle(2 * numaddr * op_cycles);
    scrub_en <= 1'b0;
    go_idle(op_cycles + mem_delay);
    for (int r = 0; r < nr; r++) begin
      if ($countones(flt_sh[r]) == 1) begin
        flt_sh[r] = '0;
      end
    end
    for (int a = 0; a < numaddr; a++) begin
      host_read(a, 1'b1);
    end
    wait_results();
    finish_test();
  endtask

  task automatic host_traffic_test();
    int k;
    int a;
    start_test("host_traffic");
    for (int i = 0; i < 3; i++) begin
      inject_fault(rand_below(nb + 1), rand_below(nr));
    end
    go_idle(1);
    scrub_en <= 1'b1;
    // status depends on scrub timing here, only data is compared
    for (int i = 0; i < 200; i++) begin
      k = rand_below(10);
      a = rand_below(numaddr);
      if (k < 4) begin
        host_read(a, 1'b0);
      end else if (k < 7) begin
        host_write(a, width'($random(seed)));
      end else begin
        go_idle(1);
      end
    end
    go_idle(1);
    scrub_en <= 1'b0;
    wait_results();
    finish_test();
  endtask

  // results are sampled away from the driving edge
  always @(negedge clk) begin : check_results
    exp_t e;
    if (!rst && read_vld) begin
      if (exp_q.size() == 0) begin
        $display("%s: read_vld with no host read outstanding", test_name);
        errors++;
      end else begin
        e = exp_q.pop_front();
        checks++;
        assert (dout === e.data) else begin
          $display("mismatch %s dout expected %h actual %h", test_name, e.data, dout);
          errors++;
        end
        if (e.chk_sts) begin
          assert ({read_serr, read_derr} === {e.serr, e.derr}) else begin
            $display("mismatch %s serr/derr expected %b%b actual %b%b", test_name,
                     e.serr, e.derr, read_serr, read_derr);
            errors++;
          end
          assert (read_padr === e.padr) else begin
            $display("mismatch %s padr expected %h actual %h", test_name, e.padr,
                     read_padr);
            errors++;
          end
        end
      end
    end
  end

  initial begin
    seed = 32'h750e_d4e0;
    rst = 1'b1;
    read = 1'b0;
    write = 1'b0;
    addr = '0;
    din = '0;
    inj = 1'b0;
    inj_bank = '0;
    inj_row = '0;
    scrub_en = 1'b0;
    errors = 0;
    checks = 0;
    n_tests = 0;
    test_name = "reset";
    for (int r = 0; r < nr; r++) begin
      flt_sh[r] = '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    go_idle(2);
    write_read_test();
    single_fault_test();
    double_fault_test();
    write_clear_test();
    scrub_sweep_test();
    host_traffic_test();
    go_idle(4);
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, total_errors());
    if (total_errors() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog sized from the op count of all tests
  initial begin
    #(limit_ns);
    $display("timeout after %0d ns, test %s did not finish", limit_ns, test_name);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== mem1rw_props.sv ====
`timescale 1ns/1ns

module mem1rw_props #(
  parameter int mem_delay = mem1rw_pkg::def_mem_delay
) (
  input logic                     clk,
  input logic                     rst,
  input logic                     read,
  input logic                     write,
  input logic                     read_vld,
  input logic                     read_serr,
  input logic                     read_derr,
  input logic                     scrub_gnt,
  input mem1rw_pkg::mem_op_e      core_op,
  input mem1rw_pkg::scrub_state_e scrub_state
);
  import mem1rw_pkg::*;

  int fail_cnt = 0;

  // host read latency is fixed in both directions
  a_read_latency: assert property (@(posedge clk) disable iff (rst)
    (read && !write) |-> ##mem_delay read_vld)
    else begin
      $error("host read without read_vld after %0d cycles", mem_delay);
      fail_cnt++;
    end

  a_no_orphan_vld: assert property (@(posedge clk) disable iff (rst)
    read_vld |-> $past(read && !write, mem_delay))
    else begin
      $error("read_vld without a host read %0d cycles before", mem_delay);
      fail_cnt++;
    end

  a_derr_has_serr: assert property (@(posedge clk) disable iff (rst)
    read_vld |-> (!read_derr || read_serr))
    else begin
      $error("read_derr high while read_serr low");
      fail_cnt++;
    end

  // host owns the core bus whenever it is active
  a_host_first: assert property (@(posedge clk) disable iff (rst)
    (read || write) |-> (!scrub_gnt && core_op == (write ? op_write : op_read)))
    else begin
      $error("scrubber request reached the core while the host was active");
      fail_cnt++;
    end

  a_reset_state: assert property (@(posedge clk)
    (rst ##1 rst) |-> (!read_vld && !scrub_gnt && scrub_state == sc_idle))
    else begin
      $error("outputs or scrubber not idle during reset");
      fail_cnt++;
    end

endmodule

bind mem1rw_top mem1rw_props #(
  .mem_delay (mem_delay)
) i_props (
  .clk         (clk),
  .rst         (rst),
  .read        (read),
  .write       (write),
  .read_vld    (read_vld),
  .read_serr   (read_serr),
  .read_derr   (read_derr),
  .scrub_gnt   (scrub_gnt),
  .core_op     (core_bus.op),
  .scrub_state (i_row_scrubber.state)
);

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int period = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // free running, half period per phase
  always begin
    #(period / 2);
    clk = ~clk;
  end

endmodule

// ==== mem1rw_top.sv ====
`timescale 1ns/1ns

module mem1rw_top #(
  parameter int width = mem1rw_pkg::def_width,
  parameter int numvbnk = mem1rw_pkg::def_numvbnk,
  parameter int numvrow = mem1rw_pkg::def_numvrow,
  parameter int numwrds = mem1rw_pkg::def_numwrds,
  parameter int mem_delay = mem1rw_pkg::def_mem_delay,
  parameter int scrub_gap = 4,
  localparam int numaddr = numvbnk * numvrow,
  localparam int numsrow = (numvrow + numwrds - 1) / numwrds,
  localparam int bitaddr = (numaddr > 1) ? $clog2(numaddr) : 1,
  localparam int bitvbnk = (numvbnk > 1) ? $clog2(numvbnk) : 1,
  localparam int bitibnk = $clog2(numvbnk + 1),
  localparam int bitvrow = (numvrow > 1) ? $clog2(numvrow) : 1,
  localparam int bitwrds = (numwrds > 1) ? $clog2(numwrds) : 1,
  localparam int bitsrow = (numsrow > 1) ? $clog2(numsrow) : 1,
  localparam int bitpadr = bitvbnk + bitwrds + bitsrow
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               read,
  input  logic               write,
  input  logic [bitaddr-1:0] addr,
  input  logic [width-1:0]   din,
  input  logic               inj,
  input  logic [bitibnk-1:0] inj_bank,
  input  logic [bitvrow-1:0] inj_row,
  input  logic               scrub_en,
  output logic               read_vld,
  output logic [width-1:0]   dout,
  output logic               read_serr,
  output logic               read_derr,
  output logic [bitpadr-1:0] read_padr
);
  import mem1rw_pkg::*;

  logic               owner;
  logic               res_owner;
  logic               scrub_gnt;
  logic               host_vld;
  logic               trk_serr;
  logic               trk_derr;
  logic [bitpadr-1:0] trk_padr;

  mem_req_if #(.width(width), .bitaddr(bitaddr), .bitpadr(bitpadr)) core_bus ();
  mem_req_if #(.width(width), .bitaddr(bitaddr), .bitpadr(bitpadr)) scrub_bus ();
  mem_req_if #(.width(width), .bitaddr(bitaddr), .bitpadr(bitpadr)) host_mon ();

  // host port seen as a bus, the scrubber snoops its writes
  assign host_mon.op = write ? op_write : (read ? op_read : op_idle);
  assign host_mon.addr = addr;
  assign host_mon.din = din;
  assign host_mon.rvld = read_vld;
  assign host_mon.rdata = dout;
  assign host_mon.serr = read_serr;
  assign host_mon.derr = read_derr;
  assign host_mon.padr = read_padr;

  mem_arbiter #(
    .width   (width),
    .numaddr (numaddr)
  ) i_mem_arbiter (
    .read      (read),
    .write     (write),
    .addr      (addr),
    .din       (din),
    .res_owner (res_owner),
    .core      (core_bus.requester),
    .scrub     (scrub_bus.server),
    .owner     (owner),
    .scrub_gnt (scrub_gnt),
    .host_vld  (host_vld)
  );

  mem_core #(
    .width     (width),
    .numaddr   (numaddr),
    .mem_delay (mem_delay),
    .bitpadr   (bitpadr)
  ) i_mem_core (
    .clk       (clk),
    .rst       (rst),
    .owner     (owner),
    .bus       (core_bus.server),
    .serr      (trk_serr),
    .derr      (trk_derr),
    .padr      (trk_padr),
    .res_owner (res_owner)
  );

  err_tracker #(
    .numvbnk (numvbnk),
    .numvrow (numvrow),
    .numwrds (numwrds)
  ) i_err_tracker (
    .clk      (clk),
    .rst      (rst),
    .req      (core_bus.monitor),
    .inj      (inj),
    .inj_bank (inj_bank),
    .inj_row  (inj_row),
    .serr     (trk_serr),
    .derr     (trk_derr),
    .padr     (trk_padr)
  );

  row_scrubber #(
    .width     (width),
    .numaddr   (numaddr),
    .scrub_gap (scrub_gap)
  ) i_row_scrubber (
    .clk      (clk),
    .rst      (rst),
    .scrub_en (scrub_en),
    .gnt      (scrub_gnt),
    .host     (host_mon.monitor),
    .bus      (scrub_bus.requester)
  );

  assign read_vld = host_vld;
  assign dout = core_bus.rdata;
  assign read_serr = core_bus.serr;
  assign read_derr = core_bus.derr;
  assign read_padr = core_bus.padr;

endmodule

// ==== row_scrubber.sv ====
`timescale 1ns/1ns

module row_scrubber #(
  parameter int width = mem1rw_pkg::def_width,
  parameter int numaddr = mem1rw_pkg::def_numvbnk * mem1rw_pkg::def_numvrow,
  parameter int scrub_gap = 4,
  localparam int bitaddr = (numaddr > 1) ? $clog2(numaddr) : 1,
  localparam int gap_w = $clog2(scrub_gap + 2)
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         scrub_en,
  input  logic         gnt,
  mem_req_if.monitor   host,
  mem_req_if.requester bus
);
  import mem1rw_pkg::*;

  scrub_state_e       state;
  logic [bitaddr-1:0] cur;
  logic [bitaddr-1:0] next_addr;
  logic [gap_w-1:0]   gap_cnt;
  logic [width-1:0]   fix_data;
  logic               hit;
  logic               host_hit_now;

  assign next_addr = (cur == bitaddr'(numaddr - 1)) ? '0 : cur + 1'b1;
  assign host_hit_now = (host.op == op_write) && (host.addr == cur);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= sc_idle;
      cur <= '0;
      gap_cnt <= '0;
      hit <= 1'b0;
    end else begin
      case (state)
        sc_idle: begin
          if (scrub_en) begin
            state <= sc_gap;
            gap_cnt <= '0;
          end
        end
        sc_gap: begin
          if (!scrub_en) begin
            state <= sc_idle;
          end else if (int'(gap_cnt) + 1 >= scrub_gap) begin
            state <= sc_read;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        sc_read: begin
          if (gnt) begin
            state <= sc_wait;
            hit <= 1'b0;
          end else if (!scrub_en) begin
            state <= sc_idle;
          end
        end
        sc_wait: begin
          // a host write to the same word makes the returned data stale
          if (host_hit_now) begin
            hit <= 1'b1;
          end
          if (bus.rvld) begin
            if (bus.serr && !bus.derr && !hit && !host_hit_now) begin
              state <= sc_fix;
            end else begin
              state <= sc_gap;
              gap_cnt <= '0;
              cur <= next_addr;
            end
          end
        end
        sc_fix: begin
          if (gnt || host_hit_now) begin
            state <= sc_gap;
            gap_cnt <= '0;
            cur <= next_addr;
          end
        end
        default: state <= sc_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == sc_wait && bus.rvld) begin
      fix_data <= bus.rdata;
    end
  end

  assign bus.op = (state == sc_read) ? op_read : ((state == sc_fix) ? op_write : op_idle);
  assign bus.addr = cur;
  assign bus.din = fix_data;

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter #(
  parameter int width = mem1rw_pkg::def_width,
  parameter int numaddr = mem1rw_pkg::def_numvbnk * mem1rw_pkg::def_numvrow,
  localparam int bitaddr = (numaddr > 1) ? $clog2(numaddr) : 1
) (
  input  logic               read,
  input  logic               write,
  input  logic [bitaddr-1:0] addr,
  input  logic [width-1:0]   din,
  input  logic               res_owner,
  mem_req_if.requester       core,
  mem_req_if.server          scrub,
  output logic               owner,
  output logic               scrub_gnt,
  output logic               host_vld
);
  import mem1rw_pkg::*;

  logic host_act;

  // host always wins, the scrubber holds its op until granted
  assign host_act = read | write;
  assign scrub_gnt = (scrub.op != op_idle) && !host_act;

  // owner tag follows the read into the core pipeline
  assign owner = scrub_gnt;

  always_comb begin
    if (write) begin
      core.op = op_write;
    end else if (read) begin
      core.op = op_read;
    end else begin
      core.op = scrub.op;
    end
  end

  assign core.addr = host_act ? addr : scrub.addr;
  assign core.din = host_act ? din : scrub.din;

  // results split by owner tag
  assign host_vld = core.rvld & ~res_owner;
  assign scrub.rvld = core.rvld & res_owner;
  assign scrub.rdata = core.rdata;
  assign scrub.serr = core.serr;
  assign scrub.derr = core.derr;
  assign scrub.padr = core.padr;

endmodule

// ==== mem_core.sv ====
`timescale 1ns/1ns

module mem_core #(
  parameter int width = mem1rw_pkg::def_width,
  parameter int numaddr = mem1rw_pkg::def_numvbnk * mem1rw_pkg::def_numvrow,
  parameter int mem_delay = mem1rw_pkg::def_mem_delay,
  parameter int bitpadr = 6
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               owner,
  mem_req_if.server          bus,
  input  logic               serr,
  input  logic               derr,
  input  logic [bitpadr-1:0] padr,
  output logic               res_owner
);
  import mem1rw_pkg::*;

  logic [width-1:0]   mem [numaddr];

  // read pipeline, stage 0 is loaded at the edge that samples the read
  logic               vld_p  [mem_delay];
  logic               own_p  [mem_delay];
  logic [width-1:0]   data_p [mem_delay];
  logic               serr_p [mem_delay];
  logic               derr_p [mem_delay];
  logic [bitpadr-1:0] padr_p [mem_delay];

  always_ff @(posedge clk) begin
    if (bus.op == op_write) begin
      mem[bus.addr] <= bus.din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_p[0] <= 1'b0;
    end else begin
      vld_p[0] <= (bus.op == op_read);
    end
  end

  always_ff @(posedge clk) begin
    if (bus.op == op_read) begin
      data_p[0] <= mem[bus.addr];
      own_p[0] <= owner;
    end
  end

  // tracker status is already registered, so it is stage 0 as it stands
  assign serr_p[0] = serr;
  assign derr_p[0] = derr;
  assign padr_p[0] = padr;

  for (genvar g = 1; g < mem_delay; g++) begin : g_stage
    always_ff @(posedge clk) begin
      if (rst) begin
        vld_p[g] <= 1'b0;
      end else begin
        vld_p[g] <= vld_p[g-1];
      end
    end

    always_ff @(posedge clk) begin
      own_p[g] <= own_p[g-1];
      data_p[g] <= data_p[g-1];
      serr_p[g] <= serr_p[g-1];
      derr_p[g] <= derr_p[g-1];
      padr_p[g] <= padr_p[g-1];
    end
  end

  assign bus.rvld = vld_p[mem_delay-1];
  assign bus.rdata = data_p[mem_delay-1];
  assign bus.serr = serr_p[mem_delay-1];
  assign bus.derr = derr_p[mem_delay-1];
  assign bus.padr = padr_p[mem_delay-1];
  assign res_owner = own_p[mem_delay-1];

endmodule

// ==== err_tracker.sv ====
`timescale 1ns/1ns

module err_tracker #(
  parameter int numvbnk = mem1rw_pkg::def_numvbnk,
  parameter int numvrow = mem1rw_pkg::def_numvrow,
  parameter int numwrds = mem1rw_pkg::def_numwrds,
  localparam int numaddr = numvbnk * numvrow,
  localparam int numsrow = (numvrow + numwrds - 1) / numwrds,
  localparam int bitvbnk = (numvbnk > 1) ? $clog2(numvbnk) : 1,
  localparam int bitibnk = $clog2(numvbnk + 1),
  localparam int bitvrow = (numvrow > 1) ? $clog2(numvrow) : 1,
  localparam int bitwrds = (numwrds > 1) ? $clog2(numwrds) : 1,
  localparam int bitsrow = (numsrow > 1) ? $clog2(numsrow) : 1,
  localparam int bitpadr = bitvbnk + bitwrds + bitsrow,
  localparam int bitcnt = $clog2(numvbnk + 2)
) (
  input  logic               clk,
  input  logic               rst,
  mem_req_if.monitor         req,
  input  logic               inj,
  input  logic [bitibnk-1:0] inj_bank,
  input  logic [bitvrow-1:0] inj_row,
  output logic               serr,
  output logic               derr,
  output logic [bitpadr-1:0] padr
);
  import mem1rw_pkg::*;

  // one fault bit per bank per row, top bit is the spare bank
  logic [numvbnk:0]   err_map [numvrow];
  logic [bitvbnk-1:0] bank;
  logic [bitvrow-1:0] row;
  logic [bitwrds-1:0] word;
  logic [bitsrow-1:0] srow;
  logic [bitcnt-1:0]  cnt;
  logic [bitibnk-1:0] low_bank;

  addr_split #(
    .numaddr (numaddr),
    .numvbnk (numvbnk),
    .numvrow (numvrow),
    .numwrds (numwrds)
  ) i_addr_split (
    .addr (req.addr),
    .bank (bank),
    .row  (row),
    .word (word),
    .srow (srow)
  );

  // count faults on the row, walking down so the lowest faulty bank is kept
  always_comb begin
    cnt = '0;
    low_bank = bitibnk'(bank);
    for (int b = numvbnk; b >= 0; b--) begin
      if (err_map[row][b]) begin
        cnt = cnt + 1'b1;
        low_bank = bitibnk'(b);
      end
    end
  end

  // clear comes after inject so a write wins on the same bit
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < numvrow; r++) begin
        err_map[r] <= '0;
      end
    end else begin
      if (inj) begin
        err_map[inj_row][inj_bank] <= 1'b1;
      end
      if (req.op == op_write) begin
        err_map[row][bank] <= 1'b0;
        err_map[row][numvbnk] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      serr <= 1'b0;
      derr <= 1'b0;
    end else if (req.op == op_read) begin
      serr <= (cnt != '0);
      derr <= (cnt > bitcnt'(1));
    end
  end

  always_ff @(posedge clk) begin
    if (req.op == op_read) begin
      padr <= {bitvbnk'(low_bank), word, srow};
    end
  end

endmodule

// ==== addr_split.sv ====
`timescale 1ns/1ns

module addr_split #(
  parameter int numaddr = 48,
  parameter int numvbnk = 3,
  parameter int numvrow = 16,
  parameter int numwrds = 2,
  localparam int numsrow = (numvrow + numwrds - 1) / numwrds,
  localparam int bitaddr = (numaddr > 1) ? $clog2(numaddr) : 1,
  localparam int bitvbnk = (numvbnk > 1) ? $clog2(numvbnk) : 1,
  localparam int bitvrow = (numvrow > 1) ? $clog2(numvrow) : 1,
  localparam int bitwrds = (numwrds > 1) ? $clog2(numwrds) : 1,
  localparam int bitsrow = (numsrow > 1) ? $clog2(numsrow) : 1
) (
  input  logic [bitaddr-1:0] addr,
  output logic [bitvbnk-1:0] bank,
  output logic [bitvrow-1:0] row,
  output logic [bitwrds-1:0] word,
  output logic [bitsrow-1:0] srow
);

  // bank interleave first, counts need not be powers of two
  assign bank = bitvbnk'(addr % numvbnk);
  assign row = bitvrow'(addr / numvbnk);

  // row is split again only for physical address reporting
  assign word = bitwrds'(row % numwrds);
  assign srow = bitsrow'(row / numwrds);

endmodule

// ==== mem_req_if.sv ====
`timescale 1ns/1ns

interface mem_req_if #(
  parameter int width = 16,
  parameter int bitaddr = 6,
  parameter int bitpadr = 6
) ();
  import mem1rw_pkg::*;

  // request side
  mem_op_e            op;
  logic [bitaddr-1:0] addr;
  logic [width-1:0]   din;

  // result side
  logic               rvld;
  logic [width-1:0]   rdata;
  logic               serr;
  logic               derr;
  logic [bitpadr-1:0] padr;

  modport requester (output op, addr, din, input rvld, rdata, serr, derr, padr);
  modport server (input op, addr, din, output rvld, rdata, serr, derr, padr);
  modport monitor (input op, addr, din, rvld, rdata, serr, derr, padr);

endinterface

// ==== mem1rw_pkg.sv ====
package mem1rw_pkg;

  // request opcode on the memory buses
  typedef enum logic [1:0] {
    op_idle,
    op_read,
    op_write
  } mem_op_e;

  // background scrubber FSM
  typedef enum logic [2:0] {
    sc_idle,
    sc_gap,
    sc_read,
    sc_wait,
    sc_fix
  } scrub_state_e;

  // default geometry, used by the top level
  localparam int def_width = 16;
  localparam int def_numvbnk = 3;
  localparam int def_numvrow = 16;
  localparam int def_numwrds = 2;
  localparam int def_mem_delay = 2;

endpackage
